// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        forever #20 clk = ~clk;        // 40 ns period
    end

    initial begin
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/debug_unit_chk.sv
`timescale 1ns/1ps

module debug_unit_chk (
    input logic clk,
    input logic rst_n,
    input logic uart_tx,
    input logic prog_we,
    input logic debug_pause,
    input logic reply_busy,
    input logic frame_req
);

    // one write strobe per word
    assert property (@(posedge clk) disable iff (!rst_n) prog_we |=> !prog_we)
        else $error("prog_we high for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n) !reply_busy |-> uart_tx)
        else $error("uart_tx low while no reply in progress");

    // a frame is only requested when the cpu has just been halted
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_req |-> (debug_pause && !$past(debug_pause)))
        else $error("frame_req without debug_pause rising");

endmodule

bind debug_unit debug_unit_chk u_chk (
    .clk(clk), .rst_n(rst_n), .uart_tx(uart_tx), .prog_we(prog_we),
    .debug_pause(debug_pause), .reply_busy(reply_busy), .frame_req(frame_req)
);

// File: bench/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit import dbg_pkg::*; ();

    localparam int bit_cycles  = 8;
    localparam int n_entries   = 6;
    localparam int reply_none  = 0;
    localparam int reply_ok    = 1;
    localparam int reply_frame = 2;

    typedef struct {
        logic [7:0]           op;
        int                   n_words;     // program words
        int                   n_steps;     // running cycles before the breakpoint
        int                   reply;
        logic                 pause_after;
        logic [isa_width-1:0] pc_base;
    } entry_t;

    logic clk, rst_n, uart_rx, uart_tx, prog_we, program_done, debug_pause;
    logic [isa_width-1:0] pc, prog_addr, prog_data;
    logic [15:0] lfsr;
    logic [7:0] rx_q [$];              // characters seen on uart_tx
    logic [isa_width-1:0] we_addr [$];
    logic [isa_width-1:0] we_data [$];
    entry_t tbl [n_entries];
    int low_cycles = 0;
    int done_cycles = 0;

    clk_gen u_clk_gen (.clk, .rst_n);

    debug_unit #(.clks_per_bit(bit_cycles)) uut (
        .clk, .rst_n, .uart_rx, .uart_tx, .pc, .prog_addr, .prog_data,
        .prog_we, .program_done, .debug_pause
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_op(input dbg_op_e got, input dbg_op_e exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERROR: %0d ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_word(input logic [isa_width-1:0] got, input logic [isa_width-1:0] exp,
                              input string what);
        if (got !== exp)
            fail_run($sformatf("ERROR: %0d ns: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERROR: %0d ns: %s got %b, expected %b", $time, what, got, exp));
    endtask

    // taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [isa_width-1:0] rand_word();
        logic [isa_width-1:0] w;
        for (int k = 0; k < isa_width; k++)
            w = {lfsr_bit(), w[isa_width-1:1]};
        return w;
    endfunction

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};    // stop, data, start
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            uart_rx <= frame[k];
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input logic [isa_width-1:0] w);
        for (int k = 0; k < isa_bytes; k++)
            send_byte(w[8*k +: 8]);
    endtask

    task automatic run_entry(input entry_t e);
        logic [isa_width-1:0] bp, w, exp_pc;
        logic [isa_width-1:0] words [$];
        logic [7:0] b;
        int low_before, done_before, n_reply;
        n_reply     = (e.reply == reply_frame) ? 5 : e.reply;
        low_before  = low_cycles;
        done_before = done_cycles;
        bp          = '0;
        @(posedge clk);
        if (e.op == op_resume) begin
            bp = rand_word();
            if (bp == '0)
                bp = 32'h1;            // zero would mean free run
            pc <= bp ^ 32'h1;
        end else begin
            pc <= e.pc_base;
        end
        exp_pc = (e.op == op_resume) ? bp : e.pc_base;
        send_byte(e.op);
        case (e.op)
            op_program: begin
                for (int k = 0; k < e.n_words; k++) begin
                    w = rand_word();
                    words.push_back(w);
                    send_word(w);
                end
                do @(posedge clk); while (!program_done);
                @(posedge clk);
                check_bit(program_done, 1'b0, "program_done after its pulse");
                check_bit(debug_pause, 1'b0, "debug_pause after program_done");
                check_word(prog_addr, {isa_width{1'b1}}, "prog_addr after program_done");
                check_word(32'(we_addr.size()), 32'(e.n_words), "prog_we count");
                for (int k = 0; k < e.n_words; k++) begin
                    check_word(we_addr.pop_front(), 32'(k), "prog_addr");
                    check_word(we_data.pop_front(), words[k], "prog_data");
                end
            end
            op_resume: begin
                send_word(bp);
                do @(posedge clk); while (debug_pause);
                for (int k = 0; k < e.n_steps; k++) begin
                    pc <= bp + 32'(k) + 32'd1;
                    @(posedge clk);
                    check_bit(debug_pause, 1'b0, "debug_pause before breakpoint");
                end
                pc <= bp;
            end
            default: ;
        endcase
        while (rx_q.size() < n_reply) @(posedge clk);
        if (e.reply == reply_ok) begin
            b = rx_q.pop_front();
            check_op(dbg_op_e'(b), op_ok, "ping reply");
        end else if (e.reply == reply_frame) begin
            b = rx_q.pop_front();
            check_op(dbg_op_e'(b), op_signal, "frame header");
            for (int k = 0; k < isa_bytes; k++)
                w[8*k +: 8] = rx_q.pop_front();
            check_word(w, exp_pc, "frame pc");
        end
        // a full frame of silence when no reply is expected
        repeat ((e.reply == reply_none) ? 50 * bit_cycles : 12 * bit_cycles) @(posedge clk);
        check_word(32'(rx_q.size()), 32'd0, "extra characters on uart_tx");
        check_word(32'(we_addr.size()), 32'd0, "unexpected prog_we");
        check_word(32'(done_cycles - done_before), (e.op == op_program) ? 32'd1 : 32'd0,
                   "program_done cycles");
        check_bit(debug_pause, e.pause_after, "debug_pause at end of command");
        if (e.op == op_next)
            check_word(32'(low_cycles - low_before), 32'd1, "cycles released by op_next");
    endtask

    // serial reader sampling uart_tx at mid-bit
    initial begin : reader
        logic [7:0] b;
        forever begin
            @(posedge clk);
            if (rst_n && uart_tx === 1'b0) begin
                repeat (bit_cycles / 2) @(posedge clk);
                for (int k = 0; k < 8; k++) begin
                    repeat (bit_cycles) @(posedge clk);
                    b[k] = uart_tx;
                end
                repeat (bit_cycles) @(posedge clk);   // into the stop bit
                rx_q.push_back(b);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && prog_we) begin
            we_addr.push_back(prog_addr);
            we_data.push_back(prog_data);
        end
        if (rst_n && !debug_pause)
            low_cycles++;
        if (rst_n && program_done)
            done_cycles++;
    end

    initial begin : watchdog
        int chars;
        chars = 0;
        #1;
        for (int i = 0; i < n_entries; i++) begin
            chars += 1 + 4 * tbl[i].n_words + ((tbl[i].op == op_resume) ? 4 : 0);
            chars += (tbl[i].reply == reply_frame) ? 5 : tbl[i].reply;
        end
        #(chars * 2 * 10 * 320);
        fail_run("the simulation timed out waiting for the DUT");
    end

    initial begin
        uart_rx <= 1'b1;
        pc      <= '0;
        lfsr = 16'd45;
        // op, words, steps, reply, pause after, pc
        tbl[0] = '{op_ping,    0, 0, reply_ok,    1'b1, 32'h0000_0000};
        tbl[1] = '{op_program, 3, 0, reply_none,  1'b0, 32'h0000_0000};
        tbl[2] = '{op_pause,   0, 0, reply_frame, 1'b1, 32'h0000_1234};
        tbl[3] = '{op_resume,  0, 5, reply_frame, 1'b1, 32'h0000_0000};
        tbl[4] = '{op_next,    0, 0, reply_frame, 1'b1, 32'h0000_0abc};
        tbl[5] = '{8'h5a,      0, 0, reply_none,  1'b1, 32'h0000_0abc};
        @(posedge rst_n);
        repeat (4) @(posedge clk);
        for (int i = 0; i < n_entries; i++)
            run_entry(tbl[i]);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: rtl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import dbg_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [uart_len-1:0]  rx_byte,
    input  logic                 rx_valid,
    input  logic                 line_quiet,
    input  logic                 reply_busy,
    output logic                 cmd_halt,
    output logic                 cmd_run,
    output logic                 cmd_step,
    output logic                 ping_req,
    output logic                 prog_we,
    output logic                 program_done,
    output logic [isa_width-1:0] breakpoint,
    output logic [isa_width-1:0] prog_addr,
    output logic [isa_width-1:0] prog_data
);

    localparam int idx_w = $clog2(isa_bytes);
    localparam logic [idx_w-1:0] last_byte = idx_w'(isa_bytes - 1);

    cmd_state_e       state;
    logic [idx_w-1:0] byte_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= cmd_opcode;
            byte_idx     <= '0;
            cmd_halt     <= 1'b0;
            cmd_run      <= 1'b0;
            cmd_step     <= 1'b0;
            ping_req     <= 1'b0;
            prog_we      <= 1'b0;
            program_done <= 1'b0;
            breakpoint   <= '0;
            prog_addr    <= '1;                // first word lands at 0
            prog_data    <= '0;
        end else begin
            cmd_halt     <= 1'b0;
            cmd_run      <= 1'b0;
            cmd_step     <= 1'b0;
            ping_req     <= 1'b0;
            prog_we      <= 1'b0;
            program_done <= 1'b0;
            case (state)
                cmd_opcode: begin
                    byte_idx <= '0;
                    if (rx_valid) begin
                        case (dbg_op_e'(rx_byte))
                            op_ping:    ping_req <= !reply_busy;
                            op_pause:   cmd_halt <= !reply_busy;
                            op_resume:  state    <= cmd_pc;
                            op_next: begin
                                cmd_step <= 1'b1;
                                state    <= cmd_next;
                            end
                            op_program: state <= cmd_program;
                            default:    state <= cmd_opcode;   // unknown byte dropped
                        endcase
                    end
                end
                cmd_program: begin
                    if (line_quiet) begin
                        // end of stream, release the cpu from address 0
                        program_done <= 1'b1;
                        cmd_run      <= 1'b1;
                        breakpoint   <= '0;
                        prog_addr    <= '1;
                        state        <= cmd_opcode;
                    end else if (rx_valid) begin
                        prog_data <= {rx_byte, prog_data[isa_width-1:uart_len]};
                        byte_idx  <= byte_idx + 1'b1;
                        if (byte_idx == last_byte) begin
                            prog_we   <= 1'b1;
                            prog_addr <= prog_addr + 1'b1;
                        end
                    end
                end
                cmd_pc: begin
                    if (rx_valid) begin
                        breakpoint <= {rx_byte, breakpoint[isa_width-1:uart_len]};
                        byte_idx   <= byte_idx + 1'b1;
                        if (byte_idx == last_byte) begin
                            cmd_run <= 1'b1;           // sees new breakpoint next cycle
                            state   <= cmd_opcode;
                        end
                    end
                end
                cmd_next: state <= cmd_opcode;         // step cycle in flight
                default:  state <= cmd_opcode;
            endcase
        end
    end

endmodule

// File: rtl/dbg_pkg.sv
package dbg_pkg;

    localparam int isa_width = 32;     // instruction and pc width
    localparam int isa_bytes = 4;      // bytes per word
    localparam int uart_len  = 8;      // data bits per character

    // single-byte opcodes on the serial line
    typedef enum logic [7:0] {
        op_signal  = 8'h01,            // to host, status frame header
        op_ok      = 8'h02,            // to host, ping answer
        op_ping    = 8'h03,
        op_pause   = 8'h04,
        op_resume  = 8'h05,            // followed by 4 breakpoint bytes
        op_next    = 8'h06,
        op_program = 8'h07             // followed by instruction words
    } dbg_op_e;

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,                      // waiting for mid start bit
        rx_data,
        rx_stop,
        rx_wait                        // gap after stop bit
    } rx_state_e;

    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_e;

    typedef enum logic [1:0] {
        cmd_opcode,
        cmd_program,
        cmd_pc,
        cmd_next
    } cmd_state_e;

    typedef enum logic [1:0] {
        reply_idle,
        reply_ok,
        reply_frame
    } reply_state_e;

endpackage

// File: rtl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit import dbg_pkg::*; #(
    parameter int clks_per_bit = 868
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 uart_rx,
    output logic                 uart_tx,
    input  logic [isa_width-1:0] pc,
    output logic [isa_width-1:0] prog_addr,
    output logic [isa_width-1:0] prog_data,
    output logic                 prog_we,
    output logic                 program_done,
    output logic                 debug_pause
);

    logic [uart_len-1:0]  rx_byte;
    logic                 rx_valid;
    logic                 line_quiet;
    logic                 cmd_halt;
    logic                 cmd_run;
    logic                 cmd_step;
    logic                 ping_req;
    logic                 reply_busy;
    logic [isa_width-1:0] breakpoint;
    logic                 frame_req;
    logic [isa_width-1:0] frame_pc;
    logic [uart_len-1:0]  tx_byte;
    logic                 tx_start;
    logic                 tx_done;

    uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
        .clk, .rst_n, .uart_rx, .rx_byte, .rx_valid, .line_quiet
    );

    // decode stage
    cmd_decode u_cmd_decode (
        .clk, .rst_n, .rx_byte, .rx_valid, .line_quiet, .reply_busy,
        .cmd_halt, .cmd_run, .cmd_step, .ping_req, .prog_we, .program_done,
        .breakpoint, .prog_addr, .prog_data
    );

    // execute stage
    run_control u_run_control (
        .clk, .rst_n, .pc, .breakpoint, .cmd_halt, .cmd_run, .cmd_step,
        .debug_pause, .frame_req, .frame_pc
    );

    // result stage
    reply_sender u_reply_sender (
        .clk, .rst_n, .ping_req, .frame_req, .frame_pc, .tx_done,
        .tx_byte, .tx_start, .reply_busy
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
        .clk, .rst_n, .tx_byte, .tx_start, .uart_tx, .tx_done
    );

endmodule

// File: rtl/reply_sender.sv
`timescale 1ns/1ps

module reply_sender import dbg_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ping_req,
    input  logic                 frame_req,
    input  logic [isa_width-1:0] frame_pc,
    input  logic                 tx_done,
    output logic [uart_len-1:0]  tx_byte,
    output logic                 tx_start,
    output logic                 reply_busy
);

    localparam int idx_w = $clog2(isa_bytes + 1);
    localparam logic [idx_w-1:0] last_byte = idx_w'(isa_bytes);

    reply_state_e         state;
    logic [idx_w-1:0]     byte_idx;    // pc bytes already queued
    logic [isa_width-1:0] pc_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= reply_idle;
            byte_idx   <= '0;
            pc_shift   <= '0;
            tx_byte    <= '0;
            tx_start   <= 1'b0;
            reply_busy <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                reply_idle: begin
                    byte_idx <= '0;
                    if (frame_req) begin           // frame wins over a ping
                        pc_shift   <= frame_pc;
                        tx_byte    <= op_signal;
                        tx_start   <= 1'b1;
                        reply_busy <= 1'b1;
                        state      <= reply_frame;
                    end else if (ping_req) begin
                        tx_byte    <= op_ok;
                        tx_start   <= 1'b1;
                        reply_busy <= 1'b1;
                        state      <= reply_ok;
                    end
                end
                reply_ok: begin
                    if (tx_done) begin
                        reply_busy <= 1'b0;
                        state      <= reply_idle;
                    end
                end
                reply_frame: begin
                    if (tx_done) begin
                        if (byte_idx == last_byte) begin
                            reply_busy <= 1'b0;
                            state      <= reply_idle;
                        end else begin
                            tx_byte  <= pc_shift[uart_len-1:0];   // lsb first
                            pc_shift <= pc_shift >> uart_len;
                            tx_start <= 1'b1;
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= reply_idle;
            endcase
        end
    end

endmodule

// File: rtl/run_control.sv
`timescale 1ns/1ps

module run_control import dbg_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [isa_width-1:0] pc,
    input  logic [isa_width-1:0] breakpoint,
    input  logic                 cmd_halt,
    input  logic                 cmd_run,
    input  logic                 cmd_step,
    output logic                 debug_pause,
    output logic                 frame_req,
    output logic [isa_width-1:0] frame_pc
);

    logic armed;                       // breakpoint compare enabled
    logic stepping;                    // the single released cycle
    logic bp_hit;
    logic halt_now;

    assign bp_hit   = !debug_pause && armed && (pc == breakpoint);
    assign halt_now = stepping || cmd_halt || bp_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_pause <= 1'b1;
            frame_req   <= 1'b0;
            frame_pc    <= '0;
            armed       <= 1'b0;
            stepping    <= 1'b0;
        end else begin
            frame_req <= 1'b0;
            stepping  <= 1'b0;
            if (halt_now) begin
                debug_pause <= 1'b1;
                frame_pc    <= pc;             // pc of the last running cycle
                frame_req   <= 1'b1;
                armed       <= 1'b0;
            end else if (cmd_step) begin
                debug_pause <= 1'b0;
                stepping    <= 1'b1;
                armed       <= 1'b0;
            end else if (cmd_run) begin
                debug_pause <= 1'b0;
                // zero breakpoint means free run
                armed       <= |breakpoint;
            end
        end
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import dbg_pkg::*; #(
    parameter int clks_per_bit = 868
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uart_rx,
    output logic [uart_len-1:0] rx_byte,
    output logic                rx_valid,
    output logic                line_quiet
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(uart_len);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [idx_w-1:0] last_bit = idx_w'(uart_len - 1);

    rx_state_e        state;
    logic [cnt_w-1:0] cnt;
    logic [idx_w-1:0] bit_idx;
    logic             line_meta;
    logic             rx_bit;

    // two-stage synchronizer, idles high like the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_meta <= 1'b1;
            rx_bit    <= 1'b1;
        end else begin
            line_meta <= uart_rx;
            rx_bit    <= line_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rx_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            rx_byte    <= '0;
            rx_valid   <= 1'b0;
            line_quiet <= 1'b0;
        end else begin
            rx_valid   <= 1'b0;
            line_quiet <= 1'b0;
            case (state)
                rx_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_bit)
                        state <= rx_start;
                end
                rx_start: begin
                    if (cnt == half_cnt) begin
                        cnt   <= '0;
                        state <= rx_bit ? rx_idle : rx_data;   // glitch if high again
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (cnt == full_cnt) begin
                        cnt     <= '0;
                        rx_byte <= {rx_bit, rx_byte[uart_len-1:1]};   // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_bit)
                            state <= rx_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (cnt == full_cnt) begin
                        cnt <= '0;
                        if (rx_bit) begin
                            rx_valid <= 1'b1;
                            state    <= rx_wait;
                        end else begin
                            state <= rx_idle;          // framing error, byte dropped
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_wait: begin
                    if (!rx_bit) begin
                        cnt   <= '0;
                        state <= rx_start;             // next char of the burst
                    end else if (cnt == full_cnt) begin
                        line_quiet <= 1'b1;
                        state      <= rx_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import dbg_pkg::*; #(
    parameter int clks_per_bit = 868
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [uart_len-1:0] tx_byte,
    input  logic                tx_start,
    output logic                uart_tx,
    output logic                tx_done
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(uart_len + 2);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [idx_w-1:0] last_bit = idx_w'(uart_len + 1);

    tx_state_e        state;
    logic [cnt_w-1:0] cnt;
    logic [idx_w-1:0] bit_idx;
    logic [uart_len:0] shift;          // data bits then stop bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '1;
            uart_tx <= 1'b1;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                tx_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (tx_start) begin
                        shift   <= {1'b1, tx_byte};
                        uart_tx <= 1'b0;               // start bit
                        state   <= tx_send;
                    end
                end
                tx_send: begin
                    if (cnt == full_cnt) begin
                        cnt <= '0;
                        if (bit_idx == last_bit) begin
                            tx_done <= 1'b1;           // stop bit finished
                            state   <= tx_idle;
                        end else begin
                            uart_tx <= shift[0];
                            shift   <= {1'b1, shift[uart_len:1]};
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f tb.f --top-module tb_debug_unit -o sim_debug_unit \
    && ./obj_dir/sim_debug_unit | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb.f
rtl/dbg_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_decode.sv
rtl/run_control.sv
rtl/reply_sender.sv
rtl/debug_unit.sv
bench/clk_gen.sv
bench/debug_unit_chk.sv
bench/tb_debug_unit.sv
